// File: build.f
+incdir+verilog
verilog/i2c_tx_pkg.sv
verilog/i2c_cmd_if.sv
verilog/i2c_cmd_dispatch.sv
verilog/i2c_byte_tx.sv
verilog/i2c_done_collect.sv
verilog/i2c_tx_array.sv
verification/tb_i2c_tx_array.sv

// File: verification/tb_i2c_tx_array.sv
// testbench for the four-channel I2C write transmitter.
// sends random commands, decodes every SDA frame and checks the reports.
`timescale 1ns/1ps
`default_nettype none

`include "i2c_tx_defs.svh"

module tb_i2c_tx_array;

    localparam int NUM_CMDS    = 200;
    localparam int CLK_PERIOD  = 4;
    localparam int WATCHDOG_NS = (NUM_CMDS * 24 + 200) * CLK_PERIOD;

    logic                      clk;
    logic                      arstn;
    logic                      s_tvalid;
    logic                      s_tready;
    logic [`I2C_CMD_WIDTH-1:0] s_tdata;
    logic [`I2C_CHAN_BITS-1:0] s_tdest;
    logic [`I2C_NUM_CHAN-1:0]  scl;
    logic [`I2C_NUM_CHAN-1:0]  sda;
    logic                      rpt_valid;
    logic [`I2C_CHAN_BITS-1:0] rpt_chan;

    logic [31:0]               lcg_state = 32'hc253;
    // per-channel command queues filled in send order.
    logic [15:0]               sent_mem [`I2C_NUM_CHAN][256];
    int                        wr_cnt [`I2C_NUM_CHAN];
    wire  [`I2C_NUM_CHAN-1:0]  fin;
    logic [`I2C_NUM_CHAN-1:0]  exp_pend;
    logic [`I2C_NUM_CHAN-1:0]  clr;
    int                        frames_done;
    int                        rpt_cnt;

    i2c_tx_array u_i2c_tx_array (
        .clk       (clk),
        .arstn     (arstn),
        .s_tvalid  (s_tvalid),
        .s_tready  (s_tready),
        .s_tdata   (s_tdata),
        .s_tdest   (s_tdest),
        .scl       (scl),
        .sda       (sda),
        .rpt_valid (rpt_valid),
        .rpt_chan  (rpt_chan)
    );

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // address, r/w, ack, data and ack bits in bus order.
    function automatic logic [17:0] frame_bits(input logic [15:0] word);
        return {word[15:9], word[8], 1'b0, word[7:0], 1'b0};
    endfunction

    function automatic logic [1:0] lowest_pending(input logic [`I2C_NUM_CHAN-1:0] v);
        logic [1:0] idx;
        logic       found;
        idx   = '0;
        found = 1'b0;
        for (int k = 0; k < `I2C_NUM_CHAN; k++) begin
            if (v[k] && !found) begin
                idx   = 2'(k);
                found = 1'b1;
            end
        end
        return idx;
    endfunction

    task automatic stop_with_error(input string what);
        $display("Error at %0t ns: %s", $time, what);
        $display("Test failed");
        $fatal(1, "simulation stopped at first error");
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired at %0t ns before all frames were reported", $time);
        $display("Test failed");
        $fatal(1, "timeout");
    end

    // one decoder per channel samples sda mid-bit on the falling clk.
    for (genvar i = 0; i < `I2C_NUM_CHAN; i++) begin : g_dec
        logic        in_frame;
        logic        prev_sda;
        logic        done_flag;
        logic [17:0] shreg;
        int          bit_cnt;
        int          rd;

        assign fin[i] = done_flag;

        always @(negedge clk or negedge arstn) begin
            if (!arstn) begin
                in_frame  = 1'b0;
                prev_sda  = 1'b1;
                done_flag = 1'b0;
                shreg     = '0;
                bit_cnt   = 0;
                rd        = 0;
            end else begin
                done_flag = 1'b0;
                if (!in_frame) begin
                    assert (scl[i]) else stop_with_error($sformatf(
                        "scl low outside a frame on channel %0d", i));
                    // start condition is sda falling with scl held high.
                    if (prev_sda && !sda[i]) begin
                        in_frame = 1'b1;
                        bit_cnt  = 0;
                    end
                end else if (bit_cnt < 18) begin
                    shreg   = {shreg[16:0], sda[i]};
                    bit_cnt = bit_cnt + 1;
                end else begin
                    assert (sda[i]) else stop_with_error($sformatf(
                        "sda not released for stop on channel %0d", i));
                    assert (rd < wr_cnt[i]) else stop_with_error($sformatf(
                        "frame on channel %0d with no command queued", i));
                    assert (shreg == frame_bits(sent_mem[i][rd])) else
                        stop_with_error($sformatf("channel %0d frame %h, expected %h",
                            i, shreg, frame_bits(sent_mem[i][rd])));
                    rd        = rd + 1;
                    in_frame  = 1'b0;
                    done_flag = 1'b1;
                end
                prev_sda = sda[i];
            end
        end
    end

    // expected report stream with one finished channel per cycle.
    always @(posedge clk or negedge arstn) begin
        if (!arstn) begin
            exp_pend    <= '0;
            frames_done <= 0;
            rpt_cnt     <= 0;
        end else begin
            clr = '0;
            if (exp_pend != '0) begin
                clr[lowest_pending(exp_pend)] = 1'b1;
            end
            if (rpt_valid) begin
                rpt_cnt <= rpt_cnt + 1;
            end
            exp_pend    <= (exp_pend & ~clr) | fin;
            frames_done <= frames_done + $countones(fin);
        end
    end

    a_reset_state: assert property (@(posedge clk)
        !arstn |-> scl == '1 && sda == '1 && !rpt_valid && s_tready)
        else stop_with_error("outputs not idle during reset");

    a_accept_fills: assert property (@(posedge clk) disable iff (!arstn)
        s_tvalid && s_tready |=> !s_tready)
        else stop_with_error("s_tready stayed high after an accept");

    // worst case is a hold behind a frame that has just started.
    a_stall_ends: assert property (@(posedge clk) disable iff (!arstn)
        $fell(s_tready) |-> ##[1:20] s_tready)
        else stop_with_error("s_tready held low past one frame");

    a_rpt_valid: assert property (@(posedge clk) disable iff (!arstn)
        rpt_valid == (exp_pend != '0))
        else stop_with_error("rpt_valid does not match finished frames");

    a_rpt_chan: assert property (@(posedge clk) disable iff (!arstn)
        rpt_valid |-> rpt_chan == lowest_pending(exp_pend))
        else stop_with_error("rpt_chan is not the lowest finished channel");

    initial begin
        logic [31:0] r1;
        logic [31:0] r2;
        logic [15:0] word;
        logic [1:0]  dest;
        int          gap;
        arstn    = 1'b1;
        s_tvalid = 1'b0;
        s_tdata  = '0;
        s_tdest  = '0;
        for (int c = 0; c < `I2C_NUM_CHAN; c++) begin
            wr_cnt[c] = 0;
        end
        #1;
        arstn = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        arstn = 1'b1;
        for (int n = 0; n < NUM_CMDS; n++) begin
            r1   = next_rand();
            r2   = next_rand();
            word = r1[31:16];
            dest = r2[31:30];
            // mostly back to back, so busy channels stall the stream.
            gap  = (r2[29:26] < 4'd10) ? 0 : int'(r2[25:22]);
            s_tvalid = 1'b0;
            repeat (gap) begin
                @(posedge clk);
                #1;
            end
            s_tvalid = 1'b1;
            s_tdata  = word;
            s_tdest  = dest;
            while (!s_tready) begin
                @(posedge clk);
                #1;
            end
            sent_mem[dest][wr_cnt[dest]] = word;
            wr_cnt[dest] = wr_cnt[dest] + 1;
            @(posedge clk);
            #1;
        end
        s_tvalid = 1'b0;
        wait (frames_done == NUM_CMDS && exp_pend == '0);
        @(posedge clk);
        #1;
        if (rpt_cnt == NUM_CMDS) begin
            $display("Test passed");
            $finish;
        end else begin
            stop_with_error($sformatf("%0d reports for %0d commands", rpt_cnt, NUM_CMDS));
        end
    end

endmodule

`default_nettype wire

// File: verilog/i2c_byte_tx.sv
// single-channel I2C write frame generator, one bit per clock.
// takes a command in IDLE and drives scl/sda for 20 cycles.
`timescale 1ns/1ps
`default_nettype none

`include "i2c_tx_defs.svh"

module i2c_byte_tx (
    input  logic  clk,
    input  logic  arstn,
    i2c_cmd_if.tx link,
    output logic  scl,
    output logic  sda
);
    import i2c_tx_pkg::*;

    localparam int CNT_W = $clog2(`I2C_DATA_WIDTH);

    tx_state_t        state;
    i2c_cmd_t         cmd_q;
    logic [CNT_W-1:0] cnt;
    logic             scl_en;
    logic             take;

    assign link.cmd_ready = (state == IDLE);
    assign link.done      = (state == STOP);
    assign take           = link.cmd_valid && link.cmd_ready;

    always_ff @(posedge clk or negedge arstn) begin
        if (!arstn) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (take) begin
                        state <= START;
                    end
                end
                START:    state <= ADDR;
                ADDR: begin
                    if (cnt == '0) begin
                        state <= RW;
                    end
                end
                RW:       state <= ACK_ADDR;
                ACK_ADDR: state <= DATA;
                DATA: begin
                    if (cnt == '0) begin
                        state <= ACK_DATA;
                    end
                end
                ACK_DATA: state <= STOP;
                STOP:     state <= IDLE;
                default:  state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            cmd_q <= link.cmd;
        end
    end

    // counts down, so it is also the msb-first bit index.
    always_ff @(posedge clk or negedge arstn) begin
        if (!arstn) begin
            cnt <= '0;
        end else begin
            case (state)
                START:      cnt <= CNT_W'(`I2C_ADDR_WIDTH - 1);
                ACK_ADDR:   cnt <= CNT_W'(`I2C_DATA_WIDTH - 1);
                ADDR, DATA: cnt <= cnt - 1'b1;
                default:    cnt <= cnt;
            endcase
        end
    end

    // half a cycle late, so scl rises mid-bit.
    always_ff @(negedge clk or negedge arstn) begin
        if (!arstn) begin
            scl_en <= 1'b0;
        end else begin
            scl_en <= !(state inside {IDLE, START, STOP});
        end
    end

    assign scl = scl_en ? ~clk : 1'b1;

    always_comb begin
        case (state)
            IDLE:     sda = 1'b1;
            START:    sda = 1'b0;
            ADDR:     sda = cmd_q.addr[cnt];
            RW:       sda = cmd_q.rw;
            ACK_ADDR: sda = 1'b0;
            DATA:     sda = cmd_q.data[cnt];
            ACK_DATA: sda = 1'b0;
            STOP:     sda = 1'b1;
            default:  sda = 1'b1;
        endcase
    end

    // a taken command runs the full 20-cycle frame with done in the last cycle.
    a_take_frame: assert property (@(posedge clk) disable iff (!arstn)
        take |=> state == START ##19 link.done ##1 state == IDLE);

endmodule

`default_nettype wire

// File: verilog/i2c_cmd_dispatch.sv
// one-entry holding stage between the command stream and the channels.
// a busy destination stalls the stream until that channel is idle.
`timescale 1ns/1ps
`default_nettype none

`include "i2c_tx_defs.svh"

module i2c_cmd_dispatch (
    input  logic                 clk,
    input  logic                 arstn,
    input  logic                 s_tvalid,
    output logic                 s_tready,
    input  i2c_tx_pkg::i2c_cmd_t s_tdata,
    input  i2c_tx_pkg::chan_t    s_tdest,
    i2c_cmd_if.disp              chan [`I2C_NUM_CHAN]
);
    import i2c_tx_pkg::*;

    logic                     full;
    i2c_cmd_t                 held_cmd;
    chan_t                    held_dest;
    logic [`I2C_NUM_CHAN-1:0] ready_vec;
    logic                     accept;
    logic                     xfer;

    assign s_tready = !full;
    assign accept   = s_tvalid && s_tready;
    assign xfer     = full && ready_vec[held_dest];

    // offer only on the named channel.
    for (genvar i = 0; i < `I2C_NUM_CHAN; i++) begin : g_chan
        assign chan[i].cmd_valid = full && (held_dest == chan_t'(i));
        assign chan[i].cmd       = held_cmd;
        assign ready_vec[i]      = chan[i].cmd_ready;
    end

    always_ff @(posedge clk or negedge arstn) begin
        if (!arstn) begin
            full <= 1'b0;
        end else if (accept) begin
            full <= 1'b1;
        end else if (xfer) begin
            full <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            held_cmd  <= s_tdata;
            held_dest <= s_tdest;
        end
    end

    // a stalled source keeps its word.
    a_src_hold: assert property (@(posedge clk) disable iff (!arstn)
        s_tvalid && !s_tready |=> s_tvalid && $stable(s_tdata) && $stable(s_tdest));

endmodule

`default_nettype wire

// File: verilog/i2c_cmd_if.sv
// per-channel link: dispatcher offers a command, transmitter takes it
// and pulses done, collector watches done.
`timescale 1ns/1ps
`default_nettype none

interface i2c_cmd_if;
    import i2c_tx_pkg::*;

    logic     cmd_valid;
    i2c_cmd_t cmd;
    logic     cmd_ready;
    logic     done;

    modport disp (
        output cmd_valid,
        output cmd,
        input  cmd_ready
    );

    modport tx (
        input  cmd_valid,
        input  cmd,
        output cmd_ready,
        output done
    );

    modport coll (
        input done
    );

endinterface

`default_nettype wire

// File: verilog/i2c_done_collect.sv
// gathers done pulses from all channels into one report stream.
// one channel per cycle, lowest index first.
`timescale 1ns/1ps
`default_nettype none

`include "i2c_tx_defs.svh"

module i2c_done_collect (
    input  logic              clk,
    input  logic              arstn,
    i2c_cmd_if.coll           chan [`I2C_NUM_CHAN],
    output logic              rpt_valid,
    output i2c_tx_pkg::chan_t rpt_chan
);
    import i2c_tx_pkg::*;

    logic [`I2C_NUM_CHAN-1:0] pend;
    logic [`I2C_NUM_CHAN-1:0] done_vec;
    logic [`I2C_NUM_CHAN-1:0] clr;

    for (genvar i = 0; i < `I2C_NUM_CHAN; i++) begin : g_done
        assign done_vec[i] = chan[i].done;
    end

    assign rpt_valid = |pend;

    // scan down so the lowest set bit wins.
    always_comb begin
        rpt_chan = '0;
        for (int i = `I2C_NUM_CHAN - 1; i >= 0; i--) begin
            if (pend[i]) begin
                rpt_chan = chan_t'(i);
            end
        end
    end

    always_comb begin
        clr = '0;
        if (rpt_valid) begin
            clr[rpt_chan] = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge arstn) begin
        if (!arstn) begin
            pend <= '0;
        end else begin
            pend <= (pend & ~clr) | done_vec;
        end
    end

    a_no_overrun: assert property (@(posedge clk) disable iff (!arstn)
        (done_vec & pend) == '0);

endmodule

`default_nettype wire

// File: verilog/i2c_tx_array.sv
// four-channel I2C write transmitter fed by a valid/ready command stream.
// reports each finished frame by channel number.
`timescale 1ns/1ps
`default_nettype none

`include "i2c_tx_defs.svh"

module i2c_tx_array (
    input  logic                      clk,
    input  logic                      arstn,
    input  logic                      s_tvalid,
    output logic                      s_tready,
    input  logic [`I2C_CMD_WIDTH-1:0] s_tdata,
    input  logic [`I2C_CHAN_BITS-1:0] s_tdest,
    output logic [`I2C_NUM_CHAN-1:0]  scl,
    output logic [`I2C_NUM_CHAN-1:0]  sda,
    output logic                      rpt_valid,
    output logic [`I2C_CHAN_BITS-1:0] rpt_chan
);
    import i2c_tx_pkg::*;

    i2c_cmd_t cmd_in;
    chan_t    dest_in;
    chan_t    rpt_sel;

    // raw word to addr/rw/data fields.
    assign cmd_in   = i2c_cmd_t'(s_tdata);
    assign dest_in  = chan_t'(s_tdest);
    assign rpt_chan = rpt_sel;

    i2c_cmd_if link [`I2C_NUM_CHAN] ();

    i2c_cmd_dispatch u_dispatch (
        .clk      (clk),
        .arstn    (arstn),
        .s_tvalid (s_tvalid),
        .s_tready (s_tready),
        .s_tdata  (cmd_in),
        .s_tdest  (dest_in),
        .chan     (link)
    );

    for (genvar i = 0; i < `I2C_NUM_CHAN; i++) begin : g_tx
        i2c_byte_tx u_tx (
            .clk   (clk),
            .arstn (arstn),
            .link  (link[i]),
            .scl   (scl[i]),
            .sda   (sda[i])
        );
    end

    i2c_done_collect u_collect (
        .clk       (clk),
        .arstn     (arstn),
        .chan      (link),
        .rpt_valid (rpt_valid),
        .rpt_chan  (rpt_sel)
    );

endmodule

`default_nettype wire

// File: verilog/i2c_tx_defs.svh
// sizes shared by the I2C transmitter array.
// include wherever channel count or field widths are needed.
`ifndef I2C_TX_DEFS_SVH
`define I2C_TX_DEFS_SVH

// number of SCL/SDA channels.
`define I2C_NUM_CHAN 4
`define I2C_CHAN_BITS 2

// command word fields, MSB to LSB: addr, rw, data.
`define I2C_ADDR_WIDTH 7
`define I2C_DATA_WIDTH 8
`define I2C_CMD_WIDTH 16

`endif

// File: verilog/i2c_tx_pkg.sv
// types shared by the I2C transmitter array.
// compile before any module or interface that imports it.
`default_nettype none

`include "i2c_tx_defs.svh"

package i2c_tx_pkg;

    // one command word, addr in the top bits.
    typedef struct packed {
        logic [`I2C_ADDR_WIDTH-1:0] addr;
        logic                       rw;
        logic [`I2C_DATA_WIDTH-1:0] data;
    } i2c_cmd_t;

    typedef logic [`I2C_CHAN_BITS-1:0] chan_t;

    // frame phases in bus order.
    typedef enum logic [2:0] {
        IDLE,
        START,
        ADDR,
        RW,
        ACK_ADDR,
        DATA,
        ACK_DATA,
        STOP
    } tx_state_t;

endpackage

`default_nettype wire
